// ==== Makefile ====
# Verilator build and run of the flow classifier testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_flow_classifier \
		-f files.f -Mdir obj_dir
	./obj_dir/Vtb_flow_classifier > sim.log 2>&1; cat sim.log
	@grep -q "^STATUS: PASS$$" sim.log || (echo "Simulation failed, see sim.log"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

// ==== files.f ====
+incdir+verif
hw/flow_pkg.sv
hw/table_ifs.sv
hw/key_hash.sv
hw/bucket_table.sv
hw/key_table.sv
hw/fid_allocator.sv
hw/probe_counter.sv
hw/lookup_fsm.sv
hw/flow_classifier.sv
verif/tb_flow_classifier.sv

// ==== hw/bucket_table.sv ====
// ==========================================================
// Bucket tables
// Two 16-bucket memories of two entries each, registered
// read, slot write at the address last read per table
// ==========================================================
`timescale 1ns/1ps

module bucket_table (
        input logic     clk,
        input logic     rst,
        bucket_if.slave bkt
);

        flow_pkg::fid_t    fid_mem [2][flow_pkg::BUCKETS][2];
        logic [1:0]        vld [2][flow_pkg::BUCKETS];
        flow_pkg::hash_t   raddr [2];
        flow_pkg::hash_t   rd_hash [2];
        flow_pkg::bucket_t rd_bkt [2];
        logic              wtab;
        logic              went;
        flow_pkg::hash_t   waddr;

        assign rd_hash[0]  = bkt.hash0;
        assign rd_hash[1]  = bkt.hash1;
        assign bkt.bucket0 = rd_bkt[0];
        assign bkt.bucket1 = rd_bkt[1];

        assign wtab  = bkt.wslot[1];               // Table select
        assign went  = bkt.wslot[0];               // Entry in bucket
        assign waddr = raddr[wtab];

        // Valid bits
        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int t = 0; t < 2; t++) begin
                                for (int b = 0; b < flow_pkg::BUCKETS; b++) begin
                                        vld[t][b] <= 2'b00;
                                end
                        end
                end else if (bkt.wr) begin
                        vld[wtab][waddr][went] <= bkt.wentry[flow_pkg::ENTRY_W-1];
                end
        end

        always_ff @(posedge clk) begin
                for (int t = 0; t < 2; t++) begin
                        if (bkt.rd) begin
                                raddr[t]  <= rd_hash[t];
                                rd_bkt[t] <= {vld[t][rd_hash[t]][1], fid_mem[t][rd_hash[t]][1],
                                              vld[t][rd_hash[t]][0], fid_mem[t][rd_hash[t]][0]};
                        end
                end
                if (bkt.wr)
                        fid_mem[wtab][waddr][went] <= bkt.wentry[flow_pkg::FID_W-1:0];
        end

endmodule

// ==== hw/fid_allocator.sv ====
// ==========================================================
// Flow id allocator
// Hands out ids in increasing order until all are used
// ==========================================================
`timescale 1ns/1ps

module fid_allocator (
        input  logic           clk,
        input  logic           rst,
        input  logic           take,
        output flow_pkg::fid_t next_fid,
        output logic           empty
);

        logic [flow_pkg::FID_W:0] used;             // Extra bit marks exhaustion

        assign next_fid = used[flow_pkg::FID_W-1:0];
        assign empty    = used[flow_pkg::FID_W];

        always_ff @(posedge clk) begin
                if (rst)
                        used <= '0;
                else if (take && !empty)
                        used <= used + 1'b1;
        end

endmodule

// ==== hw/flow_classifier.sv ====
// ==========================================================
// Flow classifier
// Two-choice hash lookup of a flow key with insertion on a
// miss, behind a four-phase req/ack handshake
// ==========================================================
`timescale 1ns/1ps

module flow_classifier (
        input  logic                clk,
        input  logic                rst,
        input  logic                req,
        input  flow_pkg::flow_key_t key,
        output logic                ack,
        output logic                hit,
        output logic                full,
        output flow_pkg::fid_t      fid
);

        flow_pkg::hash_t hash0;
        flow_pkg::hash_t hash1;
        flow_pkg::fid_t  next_fid;
        logic            empty;
        logic            take;
        logic            clear;
        logic            step;
        logic            slot_empty;
        flow_pkg::slot_t slot;
        logic            last;
        logic            free_found;
        flow_pkg::slot_t free_slot;

        bucket_if bkt_bus ();
        key_if    key_bus ();

        // ==========================================================
        // Sequencer
        // ==========================================================
        lookup_fsm u_lookup_fsm (
                .clk        (clk),
                .rst        (rst),
                .req        (req),
                .key        (key),
                .ack        (ack),
                .hit        (hit),
                .full       (full),
                .fid        (fid),
                .hash0      (hash0),
                .hash1      (hash1),
                .bkt        (bkt_bus.master),
                .kt         (key_bus.master),
                .next_fid   (next_fid),
                .empty      (empty),
                .take       (take),
                .clear      (clear),
                .step       (step),
                .slot_empty (slot_empty),
                .slot       (slot),
                .last       (last),
                .free_found (free_found),
                .free_slot  (free_slot)
        );

        probe_counter u_probe_counter (
                .clk        (clk),
                .rst        (rst),
                .clear      (clear),
                .step       (step),
                .slot_empty (slot_empty),
                .slot       (slot),
                .last       (last),
                .free_found (free_found),
                .free_slot  (free_slot)
        );

        // ==========================================================
        // Hashing, tables and id allocation
        // ==========================================================
        key_hash u_key_hash (
                .clk   (clk),
                .key   (key),
                .hash0 (hash0),
                .hash1 (hash1)
        );

        bucket_table u_bucket_table (
                .clk (clk),
                .rst (rst),
                .bkt (bkt_bus.slave)
        );

        key_table u_key_table (
                .clk (clk),
                .kt  (key_bus.slave)
        );

        fid_allocator u_fid_allocator (
                .clk      (clk),
                .rst      (rst),
                .take     (take),
                .next_fid (next_fid),
                .empty    (empty)
        );

endmodule

// ==== hw/flow_pkg.sv ====
// ==========================================================
// Flow classifier definitions
// Widths, vector types and the lookup state encoding shared
// by the hash table blocks and the lookup sequencer
// ==========================================================
package flow_pkg;

        localparam int KEY_W     = 32;
        localparam int HASH_W    = 4;
        localparam int FID_W     = 5;
        localparam int NUM_SLOTS = 4;
        localparam int SLOT_W    = $clog2(NUM_SLOTS);
        localparam int ENTRY_W   = FID_W + 1;
        localparam int BUCKETS   = 1 << HASH_W;    // Per bucket table
        localparam int FIDS      = 1 << FID_W;     // Key table depth

        typedef logic [KEY_W-1:0]     flow_key_t;
        typedef logic [HASH_W-1:0]    hash_t;
        typedef logic [FID_W-1:0]     fid_t;
        typedef logic [SLOT_W-1:0]    slot_t;      // {table, entry}
        typedef logic [ENTRY_W-1:0]   entry_t;     // {valid, fid}
        typedef logic [2*ENTRY_W-1:0] bucket_t;    // Entry 0 in low half

        typedef enum logic [2:0] {
                IDLE,
                HASH,
                READ_BUCKET,
                PROBE,
                COMPARE,
                INSERT,
                RESPOND
        } lookup_state_t;

endpackage

// ==== hw/key_hash.sv ====
// ==========================================================
// Key hash
// Nibble XOR fold of the key and of its bit-reversed copy
// ==========================================================
`timescale 1ns/1ps

module key_hash (
        input  logic                clk,
        input  flow_pkg::flow_key_t key,
        output flow_pkg::hash_t     hash0,
        output flow_pkg::hash_t     hash1
);

        function automatic flow_pkg::hash_t fold(input flow_pkg::flow_key_t k);
                flow_pkg::hash_t h;
                h = '0;
                for (int i = 0; i < flow_pkg::KEY_W / flow_pkg::HASH_W; i++) begin
                        h = h ^ k[i*flow_pkg::HASH_W +: flow_pkg::HASH_W];
                end
                return h;
        endfunction

        flow_pkg::flow_key_t key_rev;

        // Transpose for the second table
        always_comb begin
                for (int i = 0; i < flow_pkg::KEY_W; i++) begin
                        key_rev[i] = key[flow_pkg::KEY_W-1-i];
                end
        end

        always_ff @(posedge clk) begin
                hash0 <= fold(key);
                hash1 <= fold(key_rev);
        end

endmodule

// ==== hw/key_table.sv ====
// ==========================================================
// Key table
// Stored flow keys addressed by flow id, registered read
// ==========================================================
`timescale 1ns/1ps

module key_table (
        input logic  clk,
        key_if.slave kt
);

        flow_pkg::flow_key_t mem [flow_pkg::FIDS];

        always_ff @(posedge clk) begin
                if (kt.wr)
                        mem[kt.waddr] <= kt.wdata;      // Insert of a new flow
                if (kt.rd)
                        kt.rdata <= mem[kt.raddr];
        end

endmodule

// ==== hw/lookup_fsm.sv ====
// ==========================================================
// Lookup sequencer
// Hash, bucket read, slot probing, insert and handshake ack
// ==========================================================
`timescale 1ns/1ps

module lookup_fsm (
        input  logic                clk,
        input  logic                rst,
        input  logic                req,
        input  flow_pkg::flow_key_t key,
        output logic                ack,
        output logic                hit,
        output logic                full,
        output flow_pkg::fid_t      fid,
        input  flow_pkg::hash_t     hash0,
        input  flow_pkg::hash_t     hash1,
        bucket_if.master            bkt,
        key_if.master               kt,
        input  flow_pkg::fid_t      next_fid,
        input  logic                empty,
        output logic                take,
        output logic                clear,
        output logic                step,
        output logic                slot_empty,
        input  flow_pkg::slot_t     slot,
        input  logic                last,
        input  logic                free_found,
        input  flow_pkg::slot_t     free_slot
);

        flow_pkg::lookup_state_t state;
        flow_pkg::lookup_state_t nxt;
        flow_pkg::bucket_t       bkt0_q;
        flow_pkg::bucket_t       bkt1_q;
        flow_pkg::bucket_t       cur_bkt;
        flow_pkg::entry_t        cur_entry;
        flow_pkg::fid_t          cur_fid;
        logic                    cur_valid;
        logic                    key_match;
        logic                    can_ins;

        // Current candidate from the saved buckets
        assign cur_bkt    = slot[1] ? bkt1_q : bkt0_q;
        assign cur_entry  = slot[0] ? cur_bkt[2*flow_pkg::ENTRY_W-1:flow_pkg::ENTRY_W]
                                    : cur_bkt[flow_pkg::ENTRY_W-1:0];
        assign cur_valid  = cur_entry[flow_pkg::ENTRY_W-1];
        assign cur_fid    = cur_entry[flow_pkg::FID_W-1:0];
        assign slot_empty = !cur_valid;
        assign key_match  = (kt.rdata == key);
        assign can_ins    = free_found && !empty;

        assign bkt.hash0  = hash0;
        assign bkt.hash1  = hash1;
        assign bkt.wslot  = free_slot;              // First empty candidate
        assign bkt.wentry = {1'b1, next_fid};
        assign kt.raddr   = cur_fid;
        assign kt.waddr   = next_fid;
        assign kt.wdata   = key;

        always_comb begin
                nxt    = state;
                bkt.rd = 1'b0;
                bkt.wr = 1'b0;
                kt.rd  = 1'b0;
                kt.wr  = 1'b0;
                take   = 1'b0;
                clear  = 1'b0;
                step   = 1'b0;
                case (state)
                flow_pkg::IDLE: begin
                        clear = 1'b1;
                        if (req)
                                nxt = flow_pkg::HASH;
                end
                flow_pkg::HASH: begin
                        bkt.rd = 1'b1;
                        nxt    = flow_pkg::READ_BUCKET;
                end
                flow_pkg::READ_BUCKET: nxt = flow_pkg::PROBE;
                flow_pkg::PROBE: begin
                        if (cur_valid) begin
                                kt.rd = 1'b1;
                                nxt   = flow_pkg::COMPARE;
                        end else begin
                                step = 1'b1;        // Recorded as free
                                nxt  = last ? flow_pkg::INSERT : flow_pkg::PROBE;
                        end
                end
                flow_pkg::COMPARE: begin
                        if (key_match) begin
                                nxt = flow_pkg::RESPOND;
                        end else begin
                                step = 1'b1;
                                nxt  = last ? flow_pkg::INSERT : flow_pkg::PROBE;
                        end
                end
                flow_pkg::INSERT: begin
                        bkt.wr = can_ins;
                        kt.wr  = can_ins;
                        take   = can_ins;
                        nxt    = flow_pkg::RESPOND;
                end
                flow_pkg::RESPOND: begin
                        if (!req)
                                nxt = flow_pkg::IDLE;
                end
                default: nxt = flow_pkg::IDLE;
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= flow_pkg::IDLE;
                        ack   <= 1'b0;
                        hit   <= 1'b0;
                        full  <= 1'b0;
                end else begin
                        state <= nxt;
                        if (state == flow_pkg::COMPARE && key_match) begin
                                ack <= 1'b1;
                                hit <= 1'b1;
                        end else if (state == flow_pkg::INSERT) begin
                                ack  <= 1'b1;
                                full <= !can_ins;   // No slot or no id left
                        end else if (state == flow_pkg::RESPOND && !req) begin
                                ack  <= 1'b0;
                                hit  <= 1'b0;
                                full <= 1'b0;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (state == flow_pkg::READ_BUCKET) begin
                        bkt0_q <= bkt.bucket0;
                        bkt1_q <= bkt.bucket1;
                end
                if (state == flow_pkg::COMPARE && key_match)
                        fid <= cur_fid;
                else if (state == flow_pkg::INSERT)
                        fid <= can_ins ? next_fid : '0;
        end

endmodule

// ==== hw/probe_counter.sv ====
// ==========================================================
// Probe counter
// Walks the four candidate slots, remembers first empty one
// ==========================================================
`timescale 1ns/1ps

module probe_counter (
        input  logic            clk,
        input  logic            rst,
        input  logic            clear,
        input  logic            step,
        input  logic            slot_empty,
        output flow_pkg::slot_t slot,
        output logic            last,
        output logic            free_found,
        output flow_pkg::slot_t free_slot
);

        assign last = (slot == flow_pkg::slot_t'(flow_pkg::NUM_SLOTS - 1));

        always_ff @(posedge clk) begin
                if (rst || clear) begin
                        slot       <= '0;
                        free_found <= 1'b0;
                        free_slot  <= '0;
                end else if (step) begin
                        slot <= slot + 1'b1;
                        if (slot_empty && !free_found) begin
                                free_found <= 1'b1;
                                free_slot  <= slot;     // Keep only the first
                        end
                end
        end

endmodule

// ==== hw/table_ifs.sv ====
// ==========================================================
// Table access buses
// bucket_if carries the two-table bucket read and the slot
// write, key_if the key memory read and insert write
// ==========================================================
`timescale 1ns/1ps

interface bucket_if;
        logic              rd;
        flow_pkg::hash_t   hash0;
        flow_pkg::hash_t   hash1;
        logic              wr;
        flow_pkg::slot_t   wslot;
        flow_pkg::entry_t  wentry;
        flow_pkg::bucket_t bucket0;      // One cycle after rd
        flow_pkg::bucket_t bucket1;

        modport master (output rd, hash0, hash1, wr, wslot, wentry,
                        input  bucket0, bucket1);

        modport slave  (input  rd, hash0, hash1, wr, wslot, wentry,
                        output bucket0, bucket1);
endinterface

interface key_if;
        logic                rd;
        flow_pkg::fid_t      raddr;
        flow_pkg::flow_key_t rdata;      // One cycle after rd
        logic                wr;
        flow_pkg::fid_t      waddr;
        flow_pkg::flow_key_t wdata;

        modport master (output rd, raddr, wr, waddr, wdata,
                        input  rdata);

        modport slave  (input  rd, raddr, wr, waddr, wdata,
                        output rdata);
endinterface

// ==== verif/tb_checks.svh ====
// ==========================================================
// Testbench checks
// Compare tasks for flow ids and flag bits, error counters
// and the closing count line
// ==========================================================
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int value_errors    = 0;    // Wrong result values
int protocol_errors = 0;    // Handshake faults and stalls

// ==========================================================
// Value compares
// ==========================================================
task automatic check_fid(input string name,
                         input flow_pkg::fid_t exp_fid,
                         input flow_pkg::fid_t act_fid);
        if (act_fid !== exp_fid) begin
                value_errors++;
                $display("Mismatch %s fid: expected %0d, actual %0d",
                         name, exp_fid, act_fid);
        end
endtask

task automatic check_flag(input string name,
                          input string flag,
                          input logic  exp_bit,
                          input logic  act_bit);
        if (act_bit !== exp_bit) begin
                value_errors++;
                $display("Mismatch %s %s: expected %b, actual %b",
                         name, flag, exp_bit, act_bit);
        end
endtask

// ==========================================================
// Other failures
// ==========================================================
task automatic report_fault(input string what);
        protocol_errors++;
        $display("Error: %s", what);
endtask

function automatic int total_errors();
        return value_errors + protocol_errors;
endfunction

task automatic print_error_counts();
        $display("Checks done with %0d value mismatches and %0d protocol errors",
                 value_errors, protocol_errors);
endtask

`endif

// ==== verif/tb_flow_classifier.sv ====
// ==========================================================
// Flow classifier testbench
// Directed, random and fill keys through the req/ack
// handshake, checked against a model of the hash table
// ==========================================================
`timescale 1ns/1ps

module tb_flow_classifier;

        localparam int NUM_DIRECTED = 10;
        localparam int NUM_RANDOM   = 40;
        localparam int FILL_TRIES   = 64;
        localparam int MAX_STEPS    = NUM_DIRECTED + NUM_RANDOM + FILL_TRIES + 2;
        localparam int CYCLE_LIMIT  = 20 * MAX_STEPS * 13;
        localparam int ACK_WAIT     = 16;           // Longest lookup is 13 cycles

        logic                clk = 1'b0;
        logic                rst;
        logic                req;
        flow_pkg::flow_key_t key;
        logic                ack;
        logic                hit;
        logic                full;
        flow_pkg::fid_t      fid;
        int                  cycles = 0;

        // Keys of one hash class (fold 0) fill all four candidate slots
        flow_pkg::flow_key_t step_key [NUM_DIRECTED] = '{
                32'h1234_5678, 32'hcafe_0001, 32'h1234_5678, 32'h0000_0011,
                32'h0000_0022, 32'h0000_0033, 32'h0000_0044, 32'h0000_0055,
                32'h0000_0022, 32'hcafe_0001};
        int    step_hold [NUM_DIRECTED] = '{0, 0, 3, 0, 0, 0, 2, 4, 0, 1};
        string step_name [NUM_DIRECTED] = '{
                "new_key_a", "new_key_b", "repeat_a", "fill_slot0", "fill_slot1",
                "fill_slot2", "fill_slot3", "bucket_full", "stored_after_full",
                "repeat_b"};

        // Hash table model indexed by {slot, bucket}
        logic [63:0]         m_vld;
        flow_pkg::fid_t      m_fid [64];
        flow_pkg::flow_key_t m_key [flow_pkg::FIDS];
        int                  ids_used;
        int unsigned         rand_state;

        flow_classifier UUT (
                .clk  (clk),
                .rst  (rst),
                .req  (req),
                .key  (key),
                .ack  (ack),
                .hit  (hit),
                .full (full),
                .fid  (fid)
        );

        `include "tb_checks.svh"

        always #20 clk = ~clk;

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles >= CYCLE_LIMIT) begin
                        $display("Error: run did not finish within %0d cycles", CYCLE_LIMIT);
                        $display("STATUS: FAIL");
                        $finish;
                end
        end

        // ==========================================================
        // Reference model
        // ==========================================================
        function automatic flow_pkg::hash_t nibble_fold(input flow_pkg::flow_key_t k);
                return k[3:0] ^ k[7:4] ^ k[11:8] ^ k[15:12] ^
                       k[19:16] ^ k[23:20] ^ k[27:24] ^ k[31:28];
        endfunction

        function automatic logic [5:0] slot_pos(input flow_pkg::flow_key_t k,
                                                input flow_pkg::slot_t sl);
                flow_pkg::flow_key_t rev;
                rev = {<<{k}};
                return {sl, (sl[1] ? nibble_fold(rev) : nibble_fold(k))};
        endfunction

        function automatic logic has_free_slot(input flow_pkg::flow_key_t k);
                logic found;
                found = 1'b0;
                for (int s = 0; s < flow_pkg::NUM_SLOTS; s++) begin
                        if (!m_vld[slot_pos(k, flow_pkg::slot_t'(s))])
                                found = 1'b1;
                end
                return found;
        endfunction

        function automatic flow_pkg::flow_key_t key_in_class(input flow_pkg::hash_t h,
                                                             input int n);
                flow_pkg::flow_key_t k;
                k      = {8'ha5, n[15:0], 8'h00};
                k[3:0] = h ^ nibble_fold(k);                // Forces fold to h
                return k;
        endfunction

        function automatic flow_pkg::flow_key_t next_random_key();
                rand_state = rand_state * 32'd1103515245 + 32'd12345;
                return rand_state;
        endfunction

        // Expected result of one lookup and the model update on insert
        task automatic predict(input  flow_pkg::flow_key_t k,
                               output logic exp_hit,
                               output logic exp_full,
                               output flow_pkg::fid_t exp_fid);
                logic [5:0] pos;
                logic [5:0] free_pos;
                logic       free_found;
                exp_hit    = 1'b0;
                exp_full   = 1'b0;
                exp_fid    = '0;
                free_found = 1'b0;
                free_pos   = '0;
                for (int s = 0; s < flow_pkg::NUM_SLOTS; s++) begin
                        pos = slot_pos(k, flow_pkg::slot_t'(s));
                        if (m_vld[pos]) begin
                                if (!exp_hit && m_key[m_fid[pos]] == k) begin
                                        exp_hit = 1'b1;
                                        exp_fid = m_fid[pos];
                                end
                        end else if (!free_found) begin
                                free_found = 1'b1;
                                free_pos   = pos;
                        end
                end
                if (!exp_hit) begin
                        if (free_found && ids_used < flow_pkg::FIDS) begin
                                exp_fid         = flow_pkg::fid_t'(ids_used);
                                m_vld[free_pos] = 1'b1;
                                m_fid[free_pos] = exp_fid;
                                m_key[exp_fid]  = k;
                                ids_used++;
                        end else begin
                                exp_full = 1'b1;
                        end
                end
        endtask

        // ==========================================================
        // Handshake
        // ==========================================================
        task automatic run_step(input flow_pkg::flow_key_t k, input string name,
                                input int hold);
                logic           exp_hit;
                logic           exp_full;
                flow_pkg::fid_t exp_fid;
                int             waited;
                predict(k, exp_hit, exp_full, exp_fid);
                @(posedge clk);
                req <= 1'b1;
                key <= k;
                waited = 0;
                @(posedge clk);
                while (!ack && waited < ACK_WAIT) begin
                        @(posedge clk);
                        waited++;
                end
                if (!ack) begin
                        report_fault($sformatf("%s got no ack within %0d cycles", name, ACK_WAIT));
                end else begin
                        check_flag(name, "hit", exp_hit, hit);
                        check_flag(name, "full", exp_full, full);
                        if (!exp_full)
                                check_fid(name, exp_fid, fid);
                        repeat (hold) begin                 // Result must stay put
                                @(posedge clk);
                                check_flag({name, " hold"}, "ack", 1'b1, ack);
                                check_flag({name, " hold"}, "hit", exp_hit, hit);
                                check_flag({name, " hold"}, "full", exp_full, full);
                                if (!exp_full)
                                        check_fid({name, " hold"}, exp_fid, fid);
                        end
                end
                req <= 1'b0;
                waited = 0;
                @(posedge clk);
                while (ack && waited < 3) begin
                        @(posedge clk);
                        waited++;
                end
                if (ack)
                        report_fault($sformatf("%s kept ack high after req was lowered", name));
        endtask

        // ==========================================================
        // Test sequence
        // ==========================================================
        initial begin
                flow_pkg::flow_key_t k;
                int                  n;
                logic                found;
                rst        = 1'b1;
                req        = 1'b0;
                key        = '0;
                m_vld      = '0;
                ids_used   = 0;
                rand_state = 31767;
                repeat (16) @(posedge clk);
                rst <= 1'b0;
                @(posedge clk);
                check_flag("after_reset", "ack", 1'b0, ack);
                check_flag("after_reset", "hit", 1'b0, hit);
                check_flag("after_reset", "full", 1'b0, full);

                for (int i = 0; i < NUM_DIRECTED; i++)
                        run_step(step_key[i], step_name[i], step_hold[i]);

                for (int i = 0; i < NUM_RANDOM; i++) begin
                        k = next_random_key();
                        run_step(k, $sformatf("random_%0d", i), i % 3);
                end

                // Use up the remaining ids in classes that still have room
                n = 0;
                while (ids_used < flow_pkg::FIDS && n < FILL_TRIES) begin
                        k = key_in_class(n[3:0], n);
                        if (has_free_slot(k))
                                run_step(k, $sformatf("fill_%0d", n), 0);
                        n++;
                end
                if (ids_used < flow_pkg::FIDS)
                        report_fault("fill phase ended before all flow ids were used");

                found = 1'b0;
                for (int h = 0; h < 16; h++) begin
                        if (!found && has_free_slot(key_in_class(h[3:0], FILL_TRIES + h))) begin
                                k     = key_in_class(h[3:0], FILL_TRIES + h);
                                found = 1'b1;
                        end
                end
                if (found)
                        run_step(k, "ids_exhausted", 1);
                else
                        report_fault("no bucket had a free slot for the exhausted-id step");
                run_step(step_key[0], "stored_after_exhausted", 0);

                print_error_counts();
                if (total_errors() == 0)
                        $display("STATUS: PASS");
                else
                        $display("STATUS: FAIL");
                $finish;
        end

endmodule
